/* Bender.yml */
package:
  name: aes_pipe

sources:
  - src/aes_pkg.sv
  - src/aes_sbox.sv
  - src/aes_key_expand.sv
  - src/aes_round.sv
  - src/aes_128_pipe.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_aes_128_pipe.sv

/* aes_pipe.f */
+incdir+sim
src/aes_pkg.sv
src/aes_sbox.sv
src/aes_key_expand.sv
src/aes_round.sv
src/aes_128_pipe.sv
sim/tb_aes_128_pipe.sv

/* sim/aes_ref.svh */
/*
 * behavioral AES-128 encryption model for the testbench
 * field multiply by polynomial product and reduction,
 * S-box table from a brute-force inverse search,
 * key schedule step and whole-block encryption
 */
`ifndef AES_REF_SVH
`define AES_REF_SVH

// filled once by fill_sbox_table before any test runs
logic [7:0] sbox_table [256];

// carry-less product, then fold the high bits back with 0x11b
function automatic logic [7:0] field_mul(logic [7:0] a, logic [7:0] b);
    logic [14:0] prod;
    prod = '0;
    for (int i = 0; i < 8; i++)
        if (b[i])
            prod ^= {7'b0, a} << i;
    for (int i = 14; i >= 8; i--)
        if (prod[i])
            prod ^= {6'b0, 9'h11b} << (i - 8);
    return prod[7:0];
endfunction

// inverse by trying every candidate, then the affine map bit by bit
task automatic fill_sbox_table();
    logic [7:0] inv;
    logic [7:0] sb;
    for (int x = 0; x < 256; x++)
    begin
        inv = 8'h00;
        for (int y = 1; y < 256; y++)
            if (field_mul(8'(x), 8'(y)) == 8'h01)
                inv = 8'(y);
        for (int i = 0; i < 8; i++)
            sb[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^ inv[(i + 6) % 8]
                ^ inv[(i + 7) % 8];
        sbox_table[x] = sb ^ 8'h63;
    end
endtask

// row r of column c
function automatic logic [7:0] byte_at(block_t b, int r, int c);
    return b[127 - 8 * (4 * c + r) -: 8];
endfunction

// substitution and row rotation together, row r reads column c + r
function automatic block_t sub_shift(block_t s);
    block_t t;
    for (int c = 0; c < 4; c++)
        for (int r = 0; r < 4; r++)
            t[127 - 8 * (4 * c + r) -: 8] = sbox_table[byte_at(s, r, (c + r) % 4)];
    return t;
endfunction

// circulant matrix 02 03 01 01 on every column
function automatic block_t mix_columns(block_t s);
    block_t t;
    logic [7:0] a [4];
    for (int c = 0; c < 4; c++)
    begin
        for (int r = 0; r < 4; r++)
            a[r] = byte_at(s, r, c);
        for (int r = 0; r < 4; r++)
            t[127 - 8 * (4 * c + r) -: 8] = field_mul(8'h02, a[r])
                ^ field_mul(8'h03, a[(r + 1) % 4]) ^ a[(r + 2) % 4] ^ a[(r + 3) % 4];
    end
    return t;
endfunction

// one key schedule step, w0 in the top bits
function automatic block_t next_round_key(block_t k, logic [7:0] rc);
    logic [31:0] w [4];
    logic [31:0] t;
    for (int i = 0; i < 4; i++)
        w[i] = k[127 - 32 * i -: 32];
    t = {sbox_table[w[3][23:16]], sbox_table[w[3][15:8]],
         sbox_table[w[3][7:0]], sbox_table[w[3][31:24]]};
    w[0] = w[0] ^ t ^ {rc, 24'h0};
    for (int i = 1; i < 4; i++)
        w[i] ^= w[i - 1];
    return {w[0], w[1], w[2], w[3]};
endfunction

// full ten-round encryption, key expanded on the fly
function automatic block_t encrypt_block(block_t pt, block_t k);
    block_t s;
    block_t rk;
    logic [7:0] rc;
    s  = pt ^ k;
    rk = k;
    rc = 8'h01;
    for (int rnd = 1; rnd <= 10; rnd++)
    begin
        rk = next_round_key(rk, rc);
        s  = sub_shift(s);
        if (rnd != 10)
            s = mix_columns(s);
        s  = s ^ rk;
        rc = field_mul(rc, 8'h02);
    end
    return s;
endfunction

`endif

/* sim/tb_aes_128_pipe.sv */
/*
 * directed testbench for the pipelined AES-128 core
 * clock and reset, xorshift stimulus, expected-result queue,
 * compare tasks and one task per test
 */
module tb_aes_128_pipe;
    timeunit 1ns;
    timeprecision 1ps;
    import aes_pkg::*;

    localparam int LATENCY    = 11;
    localparam int WAIT_LIMIT = 50;
    localparam logic [31:0] SEED = 32'hfd23_899b;

    logic   clk;
    logic   reset;
    logic   in_valid;
    block_t plaintext;
    block_t key;
    logic   out_valid;
    block_t ciphertext;

    `include "aes_ref.svh"

    int error_count = 0;
    int check_count = 0;
    int test_count  = 0;
    // rising edges seen so far
    int cycle = 0;
    logic [31:0] rng_state;
    // blocks in flight and the edge that sampled each one
    block_t expected_q [$];
    int     sent_q [$];
    // out_valid pulses of the current test
    int pulse_count;
    int first_out;
    int last_out;

    aes_128_pipe DUT (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .plaintext  (plaintext),
        .key        (key),
        .out_valid  (out_valid),
        .ciphertext (ciphertext)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    function automatic logic [31:0] random_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic block_t random_block();
        return {random_word(), random_word(), random_word(), random_word()};
    endfunction

    task automatic check_block(string name, block_t expected, block_t actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("ERR %s expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic note_failure(string text);
        error_count++;
        $display("%s", text);
    endtask

    // outputs settled at the rising edge, looked at half a cycle later
    task automatic collect_output(string name);
        block_t expected;
        int sent;
        if (out_valid === 1'b1)
        begin
            pulse_count++;
            if (pulse_count == 1)
                first_out = cycle;
            last_out = cycle;
            if (expected_q.size() == 0)
                note_failure($sformatf("%s: out_valid high with no block in flight", name));
            else
            begin
                expected = expected_q.pop_front();
                sent     = sent_q.pop_front();
                check_block(name, expected, ciphertext);
                if (cycle - sent != LATENCY)
                    note_failure($sformatf("%s: ciphertext came %0d cycles after its input",
                        name, cycle - sent));
            end
        end
        else if (out_valid !== 1'b0)
            check_bit(name, 1'b0, out_valid);
    endtask

    // one falling edge, output first, then the next input
    task automatic step(string name, logic valid, block_t pt, block_t k, block_t expected);
        @(negedge clk);
        collect_output(name);
        in_valid  = valid;
        plaintext = pt;
        key       = k;
        if (valid)
        begin
            expected_q.push_back(expected);
            // sampled at the coming edge
            sent_q.push_back(cycle + 1);
        end
    endtask

    task automatic wait_for_outputs(string name);
        int n;
        n = 0;
        while (expected_q.size() > 0 && n < WAIT_LIMIT)
        begin
            step(name, 1'b0, '0, '0, '0);
            n++;
        end
        if (expected_q.size() > 0)
        begin
            note_failure($sformatf("%s: timeout, output never arrived for %0d blocks",
                name, expected_q.size()));
            expected_q.delete();
            sent_q.delete();
        end
    endtask

    task automatic start_test();
        pulse_count = 0;
        first_out   = 0;
        last_out    = 0;
    endtask

    task automatic report_test(string name, int errors_before);
        test_count++;
        $display("test %s: %0d errors", name, error_count - errors_before);
    endtask

    // low while reset is held, and through the fill time afterwards
    task automatic hold_reset_and_fill();
        int errors_before;
        errors_before = error_count;
        reset    = 1'b1;
        in_valid = 1'b0;
        repeat (2)
        begin
            @(negedge clk);
            check_bit("reset", 1'b0, out_valid);
        end
        reset = 1'b0;
        repeat (LATENCY + 2)
        begin
            @(negedge clk);
            check_bit("reset", 1'b0, out_valid);
        end
        report_test("reset", errors_before);
    endtask

    // single block against its published ciphertext, one pulse only
    task automatic encrypt_known_vector(string name, block_t pt, block_t k, block_t published);
        int errors_before;
        errors_before = error_count;
        start_test();
        check_block({name, "_model"}, published, encrypt_block(pt, k));
        step(name, 1'b1, pt, k, published);
        wait_for_outputs(name);
        step(name, 1'b0, '0, '0, '0);
        if (pulse_count != 1)
            note_failure($sformatf("%s: saw %0d out_valid pulses for one block",
                name, pulse_count));
        report_test(name, errors_before);
    endtask

    task automatic stream_back_to_back();
        int errors_before;
        block_t pt;
        block_t k;
        errors_before = error_count;
        start_test();
        for (int i = 0; i < 32; i++)
        begin
            pt = random_block();
            k  = random_block();
            step("back_to_back", 1'b1, pt, k, encrypt_block(pt, k));
        end
        wait_for_outputs("back_to_back");
        if (pulse_count != 32)
            note_failure($sformatf("back_to_back: %0d out_valid pulses for 32 blocks",
                pulse_count));
        else if (last_out - first_out != 31)
            note_failure("back_to_back: out_valid was not high for 32 cycles in a row");
        report_test("back_to_back", errors_before);
    endtask

    task automatic stream_with_gaps();
        int errors_before;
        int unsigned gap;
        block_t pt;
        block_t k;
        errors_before = error_count;
        start_test();
        for (int i = 0; i < 40; i++)
        begin
            // idle cycles of zero to three between blocks
            gap = random_word() % 4;
            repeat (gap)
                step("random_gaps", 1'b0, '0, '0, '0);
            pt = random_block();
            k  = random_block();
            step("random_gaps", 1'b1, pt, k, encrypt_block(pt, k));
        end
        wait_for_outputs("random_gaps");
        if (pulse_count != 40)
            note_failure($sformatf("random_gaps: %0d out_valid pulses for 40 blocks",
                pulse_count));
        report_test("random_gaps", errors_before);
    endtask

    initial
    begin
        clk       = 1'b0;
        reset     = 1'b1;
        in_valid  = 1'b0;
        plaintext = '0;
        key       = '0;
        rng_state = SEED;
        fill_sbox_table();
        hold_reset_and_fill();
        encrypt_known_vector("fips197_c1", 128'h00112233445566778899aabbccddeeff,
            128'h000102030405060708090a0b0c0d0e0f, 128'h69c4e0d86a7b0430d8cdb78070b4c55a);
        encrypt_known_vector("all_zero", '0, '0, 128'h66e94bd4ef8a2c3b884cfa59ca342b2e);
        stream_back_to_back();
        stream_with_gaps();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* src/aes_128_pipe.sv */
/*
 * fully pipelined AES-128 encryption core
 * input whitening, ten key schedule stages one cycle ahead of the state,
 * nine full rounds and a final round, valid strobe shift chain,
 * one block per cycle in, ciphertext eleven cycles later
 */
module aes_128_pipe (
    input  logic            clk,
    input  logic            reset,
    input  logic            in_valid,
    input  aes_pkg::block_t plaintext,
    input  aes_pkg::block_t key,
    output logic            out_valid,
    output aes_pkg::block_t ciphertext
);
    import aes_pkg::*;

    // edges from sampling an input to its ciphertext
    localparam int LATENCY = NUM_ROUNDS + 1;

    // whitening registers
    block_t white_state;
    block_t key0;
    // whitened state held one more cycle so it meets round key 1
    block_t aligned_state;

    // round_key[i] is ready one cycle after round_key[i-1]
    block_t round_key [NUM_ROUNDS+1];
    // state[i] is the output of round i
    block_t state [NUM_ROUNDS+1];

    // bit 0 goes with the whitening stage, the rest track the rounds
    logic [LATENCY:0] valid_pipe;

    // data path has no reset, only the strobe does
    always_ff @(posedge clk)
    begin
        white_state   <= plaintext ^ key;
        key0          <= key;
        aligned_state <= white_state;
    end

    assign round_key[0] = key0;
    assign state[0]     = aligned_state;

    // key schedule chain
    for (genvar i = 1; i <= NUM_ROUNDS; i++)
    begin : g_key
        aes_key_expand #(
            .RCON (rcon_of(i))
        ) u_key (
            .clk     (clk),
            .key_in  (round_key[i-1]),
            .key_out (round_key[i])
        );
    end

    // round chain, round i pairs state[i-1] with round_key[i]
    for (genvar i = 1; i <= NUM_ROUNDS; i++)
    begin : g_round
        aes_round #(
            .FINAL (i == NUM_ROUNDS)
        ) u_round (
            .clk       (clk),
            .state_in  (state[i-1]),
            .round_key (round_key[i]),
            .state_out (state[i])
        );
    end

    assign ciphertext = state[NUM_ROUNDS];

    // valid strobe rides alongside, no stall
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_pipe <= '0;
        end
        else
        begin
            valid_pipe <= {valid_pipe[LATENCY-1:0], in_valid};
        end
    end

    assign out_valid = valid_pipe[LATENCY];

    // strobe must be clean whenever the core is running
    a_valid_known: assert property (
        @(posedge clk) disable iff (reset) !$isunknown(out_valid)
    );

    // no output can appear before the pipeline has had time to fill
    a_fill_after_reset: assert property (
        @(posedge clk) $fell(reset) |-> !out_valid [*LATENCY]
    );

endmodule

/* src/aes_key_expand.sv */
/*
 * one stage of the AES-128 key schedule
 * RotWord, SubWord and the round constant on the last word,
 * chained xor for the four new words, registered output
 */
module aes_key_expand #(
    parameter aes_pkg::byte_t RCON = 8'h01
) (
    input  logic            clk,
    input  aes_pkg::block_t key_in,
    output aes_pkg::block_t key_out
);
    import aes_pkg::*;

    // previous round key split into words, w0 in the top bits
    word_t w0, w1, w2, w3;
    // rotated and substituted last word
    word_t rot_word;
    word_t sub_word;
    word_t temp;
    // next round key words
    word_t n0, n1, n2, n3;

    assign w0 = key_in[127:96];
    assign w1 = key_in[95:64];
    assign w2 = key_in[63:32];
    assign w3 = key_in[31:0];

    // RotWord moves the top byte to the bottom
    assign rot_word = {w3[23:0], w3[31:24]};

    // SubWord, one S-box per byte
    for (genvar b = 0; b < 4; b++)
    begin : g_subword
        aes_sbox u_sbox (
            .in  (rot_word[31-8*b -: 8]),
            .out (sub_word[31-8*b -: 8])
        );
    end

    // round constant only touches the first byte
    assign temp = sub_word ^ {RCON, 24'h000000};

    // each new word feeds the next
    assign n0 = w0 ^ temp;
    assign n1 = w1 ^ n0;
    assign n2 = w2 ^ n1;
    assign n3 = w3 ^ n2;

    always_ff @(posedge clk)
    begin
        key_out <= {n0, n1, n2, n3};
    end

endmodule

/* src/aes_pkg.sv */
/*
 * shared AES-128 definitions
 * block, word and byte types, round count,
 * GF(2^8) xtime and the key schedule round constant
 */
package aes_pkg;

    // 128-bit block, byte 0 in bits [127:120], column-major as in FIPS-197
    typedef logic [127:0] block_t;
    // one key word or one state column
    typedef logic [31:0] word_t;
    // one field element
    typedef logic [7:0] byte_t;

    localparam int NUM_ROUNDS = 10;

    // multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic byte_t xtime(byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // round constant for rounds 1..10: 01, 02, 04 ... 80, 1b, 36
    function automatic byte_t rcon_of(int unsigned round);
        byte_t rc;
        rc = 8'h01;
        for (int unsigned i = 1; i < round; i++)
        begin
            rc = xtime(rc);
        end
        return rc;
    endfunction

endpackage

/* src/aes_round.sv */
/*
 * one registered AES cipher round
 * SubBytes, ShiftRows, MixColumns unless FINAL is set,
 * then AddRoundKey into the output register
 */
module aes_round #(
    parameter bit FINAL = 1'b0
) (
    input  logic            clk,
    input  aes_pkg::block_t state_in,
    input  aes_pkg::block_t round_key,
    output aes_pkg::block_t state_out
);
    import aes_pkg::*;

    // one column through MixColumns
    // rows of the matrix are 2 3 1 1 rotated
    function automatic word_t mix_column(word_t col);
        byte_t a0;
        byte_t a1;
        byte_t a2;
        byte_t a3;
        byte_t b0;
        byte_t b1;
        byte_t b2;
        byte_t b3;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        b0 = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
        b1 = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
        b2 = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
        b3 = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
        return {b0, b1, b2, b3};
    endfunction

    // substituted bytes, index n is row n%4 of column n/4
    byte_t sub_bytes [16];
    // after the row rotation
    byte_t shifted [16];
    // columns before and after mixing
    word_t col_in  [4];
    word_t col_out [4];
    // result before the key is added
    block_t next_state;

    // SubBytes
    for (genvar n = 0; n < 16; n++)
    begin : g_sub
        aes_sbox u_sbox (
            .in  (state_in[127-8*n -: 8]),
            .out (sub_bytes[n])
        );
    end

    // ShiftRows
    // row r rotates left by r, so (r,c) takes the byte from (r,(c+r) mod 4)
    for (genvar n = 0; n < 16; n++)
    begin : g_shift
        assign shifted[n] = sub_bytes[4*(((n/4) + (n%4)) % 4) + (n%4)];
    end

    // MixColumns per column, bypassed in the last round
    for (genvar c = 0; c < 4; c++)
    begin : g_col
        assign col_in[c] = {shifted[4*c], shifted[4*c+1], shifted[4*c+2], shifted[4*c+3]};

        if (FINAL)
        begin : g_final
            assign col_out[c] = col_in[c];
        end
        else
        begin : g_mix
            assign col_out[c] = mix_column(col_in[c]);
        end

        assign next_state[127-32*c -: 32] = col_out[c];
    end

    // AddRoundKey, then register
    always_ff @(posedge clk)
    begin
        state_out <= next_state ^ round_key;
    end

endmodule

/* src/aes_sbox.sv */
/*
 * AES S-box, purely combinational
 * multiplicative inverse in GF(2^8) by an addition chain for x^254,
 * then the affine transform with constant 0x63
 */
module aes_sbox (
    input  aes_pkg::byte_t in,
    output aes_pkg::byte_t out
);
    import aes_pkg::*;

    // shift-and-add field multiply built on xtime
    function automatic byte_t gf_mul(byte_t a, byte_t b);
        byte_t acc;
        byte_t sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
            begin
                acc ^= sh;
            end
            sh = xtime(sh);
        end
        return acc;
    endfunction

    // b ^ rotl1 ^ rotl2 ^ rotl3 ^ rotl4 ^ 0x63
    function automatic byte_t affine(byte_t b);
        byte_t r1;
        byte_t r2;
        byte_t r3;
        byte_t r4;
        r1 = {b[6:0], b[7]};
        r2 = {b[5:0], b[7:6]};
        r3 = {b[4:0], b[7:5]};
        r4 = {b[3:0], b[7:4]};
        return b ^ r1 ^ r2 ^ r3 ^ r4 ^ 8'h63;
    endfunction

    // powers of the input on the way to x^254
    byte_t p2, p3, p6, p7, p14, p15, p30, p31;
    byte_t p62, p63, p126, p127, inv;

    // x^127 via alternating square and multiply
    assign p2   = gf_mul(in, in);
    assign p3   = gf_mul(p2, in);
    assign p6   = gf_mul(p3, p3);
    assign p7   = gf_mul(p6, in);
    assign p14  = gf_mul(p7, p7);
    assign p15  = gf_mul(p14, in);
    assign p30  = gf_mul(p15, p15);
    assign p31  = gf_mul(p30, in);
    assign p62  = gf_mul(p31, p31);
    assign p63  = gf_mul(p62, in);
    assign p126 = gf_mul(p63, p63);
    assign p127 = gf_mul(p126, in);

    // x^254 = x^-1 for nonzero x, and 0 stays 0 on its own
    assign inv = gf_mul(p127, p127);

    assign out = affine(inv);

endmodule
